/* src/palframe_pkg.sv */
// Palette frame types
package palframe_pkg;

  // Bright, green, red, blue
  typedef logic [3:0] zx_color_t;

  // ULAplus colour, paper set when the group is paper
  typedef struct packed {
    logic [1:0] palsel;
    logic       paper;
    logic [2:0] shade;
  } up_color_t;

  typedef logic [6:0] pal_index_t;

  // Palette byte, RRRGGGBB
  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [1:0] b;
  } pal_entry_t;

  // Output colour, green first
  typedef struct packed {
    logic [1:0] g;
    logic [1:0] r;
    logic [1:0] b;
  } rgb_t;

  // ATM write word, GGRRBB
  typedef struct packed {
    logic [1:0] g;
    logic [1:0] r;
    logic [1:0] b;
  } atm_data_t;

  localparam pal_index_t PAL_ZX_BASE = 7'd0;
  localparam pal_index_t PAL_UP_BASE = 7'd64;

endpackage

/* src/pal_wr_if.sv */
// Palette write ports
`timescale 1ns/1ns

interface pal_wr_if;
  import palframe_pkg::*;

  // ATM port, addressed by the current standard colour
  logic       atm_palwr;
  atm_data_t  atm_data;
  zx_color_t  zx_index;

  // ULAplus port
  logic       up_palwr;
  logic [5:0] up_addr;
  pal_entry_t up_data;

  modport src (
    output atm_palwr, atm_data, up_palwr, up_addr, up_data, zx_index
  );

  modport sink (
    input atm_palwr, atm_data, up_palwr, up_addr, up_data, zx_index
  );

endinterface

/* src/color_select.sv */
// Pixel colour selection
`timescale 1ns/1ns

module color_select (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   hpix,
  input  logic                   vpix,
  input  palframe_pkg::zx_color_t pixels,
  input  palframe_pkg::zx_color_t border,
  input  logic                   border_sync,
  input  logic                   border_sync_ena,
  input  logic                   up_ena,
  input  logic [1:0]             up_palsel,
  input  logic [2:0]             up_ink,
  input  logic [2:0]             up_paper,
  input  logic                   up_pixel,
  output palframe_pkg::pal_index_t pal_index,
  pal_wr_if.src                  wr
);
  import palframe_pkg::*;

  zx_color_t synced_border;
  zx_color_t zxcolor;
  up_color_t up_color;
  logic      active;

  assign active = hpix & vpix;

  // Border latched only on the sync strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      synced_border <= '0;
    end else if (border_sync) begin
      synced_border <= border;
    end
  end

  always_comb begin
    if (active) begin
      zxcolor = pixels;
    end else if (border_sync_ena) begin
      zxcolor = synced_border;
    end else begin
      zxcolor = border;
    end
  end

  // ULAplus group is paper when the pixel is clear
  always_comb begin
    if (active) begin
      up_color.palsel = up_palsel;
      up_color.paper  = ~up_pixel;
      up_color.shade  = up_pixel ? up_ink : up_paper;
    end else begin
      up_color.palsel = 2'b00;
      up_color.paper  = 1'b0;
      up_color.shade  = border[2:0];
    end
  end

  always_comb begin
    if (up_ena) begin
      pal_index = PAL_UP_BASE + {1'b0, up_color};
    end else begin
      pal_index = PAL_ZX_BASE + {3'b000, zxcolor};
    end
  end

  // ATM writes land on the standard colour shown now
  assign wr.zx_index = zxcolor;

endmodule

/* src/palette_ram.sv */
// 128 entry palette memory
`timescale 1ns/1ns

module palette_ram (
  input  logic                     clk,
  input  logic                     arst_n,
  pal_wr_if.sink                   wr,
  input  palframe_pkg::pal_index_t pal_index,
  output palframe_pkg::pal_entry_t pal_entry
);
  import palframe_pkg::*;

  pal_entry_t palette [128];

  logic       wr_en;
  pal_index_t wr_addr;
  pal_entry_t wr_data;

  // ATM port wins a collision
  always_comb begin
    wr_en = wr.atm_palwr | wr.up_palwr;
    if (wr.atm_palwr) begin
      wr_addr   = PAL_ZX_BASE + {3'b000, wr.zx_index};
      wr_data.r = {wr.atm_data.r, 1'b0};
      wr_data.g = {wr.atm_data.g, 1'b0};
      wr_data.b = wr.atm_data.b;
    end else begin
      wr_addr = PAL_UP_BASE + {1'b0, wr.up_addr};
      wr_data = wr.up_data;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      palette[wr_addr] <= wr_data;
    end
  end

  // Read sees the old contents on a same-edge write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pal_entry <= '0;
    end else begin
      pal_entry <= palette[pal_index];
    end
  end

endmodule

/* src/rgb_encode.sv */
// Palette byte to RGB output
`timescale 1ns/1ns

module rgb_encode (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     hblank,
  input  logic                     vblank,
  input  palframe_pkg::pal_entry_t pal_entry,
  output palframe_pkg::rgb_t       color
);
  import palframe_pkg::*;

  rgb_t rgb_raw;
  logic hblank_q;
  logic vblank_q;

  // 3 bit channel down to 2 bits
  function automatic logic [1:0] map3(input logic [2:0] code);
    logic [1:0] lvl;
    case (code)
      3'd0:    lvl = 2'd0;
      3'd1:    lvl = 2'd1;
      3'd2:    lvl = 2'd3;
      3'd3:    lvl = 2'd2;
      3'd4:    lvl = 2'd0;
      3'd5:    lvl = 2'd2;
      3'd6:    lvl = 2'd3;
      default: lvl = 2'd1;
    endcase
    return lvl;
  endfunction

  function automatic logic [1:0] map2(input logic [1:0] code);
    logic [1:0] lvl;
    lvl = {code[1], code[1] ^ code[0]};
    return lvl;
  endfunction

  // Blanking delayed to meet the registered read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hblank_q <= 1'b0;
      vblank_q <= 1'b0;
    end else begin
      hblank_q <= hblank;
      vblank_q <= vblank;
    end
  end

  assign rgb_raw.g = map3(pal_entry.g);
  assign rgb_raw.r = map3(pal_entry.r);
  assign rgb_raw.b = map2(pal_entry.b);

  assign color = (hblank_q | vblank_q) ? '0 : rgb_raw;

endmodule

/* src/video_palframe.sv */
// Video palette frame stage
`timescale 1ns/1ns

module video_palframe (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     hpix,
  input  logic                     vpix,
  input  logic                     hblank,
  input  logic                     vblank,
  input  palframe_pkg::zx_color_t  pixels,
  input  palframe_pkg::zx_color_t  border,
  input  logic                     border_sync,
  input  logic                     border_sync_ena,
  input  logic                     up_ena,
  input  logic [1:0]               up_palsel,
  input  logic [2:0]               up_ink,
  input  logic [2:0]               up_paper,
  input  logic                     up_pixel,
  input  logic                     atm_palwr,
  input  palframe_pkg::atm_data_t  atm_paldata,
  input  logic                     up_palwr,
  input  logic [5:0]               up_paladdr,
  input  palframe_pkg::pal_entry_t up_paldata,
  output palframe_pkg::rgb_t       color
);
  import palframe_pkg::*;

  pal_index_t pal_index;
  pal_entry_t pal_entry;

  pal_wr_if u_wr ();

  // Write strobes come straight from the pins
  assign u_wr.atm_palwr = atm_palwr;
  assign u_wr.atm_data  = atm_paldata;
  assign u_wr.up_palwr  = up_palwr;
  assign u_wr.up_addr   = up_paladdr;
  assign u_wr.up_data   = up_paldata;

  color_select u_color_select (
    .clk             (clk),
    .arst_n          (arst_n),
    .hpix            (hpix),
    .vpix            (vpix),
    .pixels          (pixels),
    .border          (border),
    .border_sync     (border_sync),
    .border_sync_ena (border_sync_ena),
    .up_ena          (up_ena),
    .up_palsel       (up_palsel),
    .up_ink          (up_ink),
    .up_paper        (up_paper),
    .up_pixel        (up_pixel),
    .pal_index       (pal_index),
    .wr              (u_wr.src)
  );

  palette_ram u_palette_ram (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr        (u_wr.sink),
    .pal_index (pal_index),
    .pal_entry (pal_entry)
  );

  rgb_encode u_rgb_encode (
    .clk       (clk),
    .arst_n    (arst_n),
    .hblank    (hblank),
    .vblank    (vblank),
    .pal_entry (pal_entry),
    .color     (color)
  );

endmodule

/* dv/palframe_checker.sv */
// Colour output checker
`timescale 1ns/1ns

module palframe_checker (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [5:0] color,
  input  logic       line_valid,
  input  int         line_test,
  input  logic [5:0] line_exp
);

  int         errors;
  int         checks;
  int         test_errors;
  int         test_checks;
  int         cur_test;
  logic       cap_valid;
  int         cap_test;
  logic [5:0] cap_exp;

  initial begin
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    test_checks = 0;
    cur_test    = -1;
    cap_valid   = 1'b0;
    cap_test    = 0;
    cap_exp     = '0;
  end

  // Line applied last cycle, its result shows after this edge
  always @(posedge clk) begin
    cap_valid = line_valid;
    cap_test  = line_test;
    cap_exp   = line_exp;
  end

  task automatic close_test();
    if (cur_test >= 0) begin
      $display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  always @(negedge clk) begin
    if (!arst_n) begin
      checks = checks + 1;
      if (color !== 6'd0) begin
        errors = errors + 1;
        $display("ERR t=%0t color exp=%h got=%h (in reset)", $time, 6'd0, color);
      end
    end else if (cap_valid) begin
      if (cap_test != cur_test) begin
        close_test();
        cur_test = cap_test;
      end
      checks      = checks + 1;
      test_checks = test_checks + 1;
      if (color !== cap_exp) begin
        errors      = errors + 1;
        test_errors = test_errors + 1;
        $display("ERR t=%0t color exp=%h got=%h", $time, cap_exp, color);
      end
    end
  end

endmodule

/* dv/palframe_assertions.sv */
// Palette write and read checks
`timescale 1ns/1ns

module palframe_assertions (
  input logic       clk,
  input logic       arst_n,
  input logic       atm_palwr,
  input logic [5:0] atm_data,
  input logic [3:0] zx_index,
  input logic       up_palwr,
  input logic [5:0] up_addr,
  input logic [6:0] pal_index,
  input logic [7:0] pal_entry,
  input logic [7:0] mem [128]
);

  logic [6:0] up_wa;
  logic [6:0] up_wa_q;
  logic [7:0] up_old_q;
  logic [6:0] atm_wa_q;
  logic [7:0] atm_exp_q;
  logic [7:0] rd_exp_q;
  logic       live_q;

  assign up_wa = 7'd64 + {1'b0, up_addr};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      live_q    <= 1'b0;
      up_wa_q   <= '0;
      up_old_q  <= '0;
      atm_wa_q  <= '0;
      atm_exp_q <= '0;
      rd_exp_q  <= '0;
    end else begin
      live_q    <= 1'b1;
      up_wa_q   <= up_wa;
      up_old_q  <= mem[up_wa];
      atm_wa_q  <= {3'b000, zx_index};
      // RRR GGG BB from GG RR BB
      atm_exp_q <= {atm_data[3:2], 1'b0, atm_data[5:4], 1'b0, atm_data[1:0]};
      rd_exp_q  <= mem[pal_index];
    end
  end

  atm_layout: assert property (@(posedge clk) disable iff (!arst_n)
    atm_palwr |=> mem[atm_wa_q] === atm_exp_q)
    else $error("ATM write stored the wrong entry");

  collision_drop: assert property (@(posedge clk) disable iff (!arst_n)
    (atm_palwr && up_palwr) |=> mem[up_wa_q] === up_old_q)
    else $error("ULAplus write not dropped on collision");

  read_timing: assert property (@(posedge clk) disable iff (!arst_n)
    live_q |-> pal_entry === rd_exp_q)
    else $error("Palette read not one cycle behind index");

endmodule

/* dv/tb_video_palframe.sv */
// Palette frame testbench
`timescale 1ns/1ns

module tb_video_palframe;
  import palframe_pkg::*;

  localparam int MAX_LINES = 256;

  logic       clk;
  logic       arst_n;
  logic       hpix, vpix, hblank, vblank;
  logic [3:0] pixels, border;
  logic       border_sync, border_sync_ena;
  logic       up_ena, up_pixel;
  logic [1:0] up_palsel;
  logic [2:0] up_ink, up_paper;
  logic       atm_palwr, up_palwr;
  logic [5:0] atm_paldata, up_paladdr;
  logic [7:0] up_paldata;
  rgb_t       color;

  logic       line_valid;
  int         line_test;
  logic [5:0] line_exp;

  int vec [MAX_LINES][20];
  int n_lines;
  int cycles;
  int limit;

  video_palframe dut (
    .clk(clk), .arst_n(arst_n), .hpix(hpix), .vpix(vpix),
    .hblank(hblank), .vblank(vblank), .pixels(pixels), .border(border),
    .border_sync(border_sync), .border_sync_ena(border_sync_ena),
    .up_ena(up_ena), .up_palsel(up_palsel), .up_ink(up_ink),
    .up_paper(up_paper), .up_pixel(up_pixel), .atm_palwr(atm_palwr),
    .atm_paldata(atm_paldata), .up_palwr(up_palwr),
    .up_paladdr(up_paladdr), .up_paldata(up_paldata), .color(color)
  );

  palframe_checker u_checker (
    .clk(clk), .arst_n(arst_n), .color(color),
    .line_valid(line_valid), .line_test(line_test), .line_exp(line_exp)
  );

  bind palette_ram palframe_assertions u_assertions (
    .clk(clk), .arst_n(arst_n), .atm_palwr(wr.atm_palwr),
    .atm_data(wr.atm_data), .zx_index(wr.zx_index), .up_palwr(wr.up_palwr),
    .up_addr(wr.up_addr), .pal_index(pal_index), .pal_entry(pal_entry),
    .mem(palette)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic read_trace();
    int    fd;
    int    code;
    int    f [20];
    string line;
    fd = $fopen("dv/palframe_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file dv/palframe_trace.txt");
      return;
    end
    while (!$feof(fd) && n_lines < MAX_LINES) begin
      code = $fgets(line, fd);
      if (code > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
          f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
        if (code == 20) begin
          vec[n_lines] = f;
          n_lines = n_lines + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_line(input int k);
    line_test       = vec[k][0];
    hpix            = vec[k][1][0];
    vpix            = vec[k][2][0];
    hblank          = vec[k][3][0];
    vblank          = vec[k][4][0];
    pixels          = vec[k][5][3:0];
    border          = vec[k][6][3:0];
    border_sync     = vec[k][7][0];
    border_sync_ena = vec[k][8][0];
    up_ena          = vec[k][9][0];
    up_palsel       = vec[k][10][1:0];
    up_ink          = vec[k][11][2:0];
    up_paper        = vec[k][12][2:0];
    up_pixel        = vec[k][13][0];
    atm_palwr       = vec[k][14][0];
    atm_paldata     = vec[k][15][5:0];
    up_palwr        = vec[k][16][0];
    up_paladdr      = vec[k][17][5:0];
    up_paldata      = vec[k][18][7:0];
    line_exp        = vec[k][19][5:0];
    line_valid      = 1'b1;
  endtask

  initial begin
    arst_n = 1'b0;
    {hpix, vpix, hblank, vblank, border_sync, border_sync_ena} = '0;
    {up_ena, up_pixel, atm_palwr, up_palwr} = '0;
    pixels = '0;
    border = '0;
    up_palsel = '0;
    up_ink = '0;
    up_paper = '0;
    atm_paldata = '0;
    up_paladdr = '0;
    up_paldata = '0;
    line_valid = 1'b0;
    line_test = 0;
    line_exp = '0;
    cycles = 0;
    limit = 0;
    n_lines = 0;
    read_trace();
    limit = 4 * n_lines + 20;
    repeat (4) @(posedge clk);
    #2 arst_n = 1'b1;
    for (int k = 0; k < n_lines; k++) begin
      @(posedge clk);
      #2 apply_line(k);
    end
    @(posedge clk);
    #2 line_valid = 1'b0;
    @(posedge clk);
    @(negedge clk);
    u_checker.close_test();
    $display("checks %0d, errors %0d, trace lines %0d", u_checker.checks,
      u_checker.errors, n_lines);
    if (u_checker.errors == 0 && n_lines > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* dv/palframe_trace.txt */
# test hpix vpix hblank vblank pixels border border_sync border_sync_ena up_ena up_palsel
# up_ink up_paper up_pixel atm_palwr atm_paldata up_palwr up_paladdr up_paldata exp_color
1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 00 0 00 00 00
1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 00 0 00 00 00
2 1 1 1 0 1 0 0 0 0 0 0 0 0 1 1B 0 00 00 00
2 1 1 1 0 2 0 0 0 0 0 0 0 0 1 35 0 00 00 00
2 1 1 1 0 5 0 0 0 0 0 0 0 0 1 0E 0 00 00 00
2 1 1 1 0 0 0 0 0 0 0 0 0 0 1 11 0 00 00 00
2 1 1 0 0 1 0 0 0 0 0 0 0 0 0 00 0 00 00 32
2 1 1 0 0 2 0 0 0 0 0 0 0 0 0 00 0 00 00 3D
2 1 1 0 0 5 0 0 0 0 0 0 0 0 0 00 0 00 00 0F
2 1 1 0 0 0 0 0 0 0 0 0 0 0 0 00 0 00 00 31
3 0 0 0 0 0 1 1 1 0 0 0 0 0 0 00 0 00 00 31
3 0 0 0 0 0 2 0 1 0 0 0 0 0 0 00 0 00 00 32
3 0 0 0 0 0 2 1 1 0 0 0 0 0 0 00 0 00 00 32
3 0 0 0 0 0 2 0 1 0 0 0 0 0 0 00 0 00 00 3D
3 0 0 0 0 0 5 0 0 0 0 0 0 0 0 00 0 00 00 0F
4 1 1 1 0 0 0 0 0 0 0 0 0 0 0 00 1 0B 2E 00
4 1 1 1 0 0 0 0 0 0 0 0 0 0 0 00 1 05 F5 00
4 1 1 1 0 0 0 0 0 0 0 0 0 0 0 00 1 2B 47 00
4 1 1 1 0 0 0 0 0 0 0 0 0 0 0 00 1 06 B8 00
4 1 1 0 0 0 0 0 0 1 0 5 3 0 0 00 0 00 00 27
4 1 1 0 0 0 0 0 0 1 0 5 3 1 0 00 0 00 00 25
4 1 1 0 0 0 0 0 0 1 2 5 3 0 0 00 0 00 00 1E
4 0 0 0 0 0 6 0 0 1 0 5 3 0 0 00 0 00 00 38
5 1 1 1 0 0 0 0 0 0 0 0 0 0 1 3F 1 0B 00 00
5 1 1 0 0 0 0 0 0 0 0 0 0 0 0 00 0 00 00 3E
5 1 1 0 0 0 0 0 0 1 0 5 3 0 0 00 0 00 00 27
6 1 1 1 0 1 0 0 0 0 0 0 0 0 0 00 0 00 00 00
6 1 1 0 1 1 0 0 0 0 0 0 0 0 0 00 0 00 00 00
6 1 1 0 0 1 0 0 0 0 0 0 0 0 0 00 0 00 00 32

/* project.f */
src/palframe_pkg.sv
src/pal_wr_if.sv
src/color_select.sv
src/palette_ram.sv
src/rgb_encode.sv
src/video_palframe.sv
dv/palframe_checker.sv
dv/palframe_assertions.sv
dv/tb_video_palframe.sv

/* Makefile */
TOP             ?= tb_video_palframe
FILELIST        ?= project.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --assert
OBJ_DIR         ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	$(VERILATOR) --lint-only --timing $(VERILATOR_FLAGS) --top-module $(TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
